// File: cache.f
+incdir+include
source/cache_pkg.sv
source/cache_tag_store.sv
source/cache_data_store.sv
source/cache_controller.sv
source/cache_top.sv
testbench/cache_checker.sv
testbench/tb_cache.sv

// File: include/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// byte address width on the processor side
`define CACHE_ADDR_W 32

// one cache line holds one word of this width
`define CACHE_DATA_W 32

// set index width, 16 sets
`define CACHE_SET_BITS 4

// associativity
// fixed at four, the two-bit age encoding relies on it
`define CACHE_WAYS 4

// tag is what remains above set index and byte offset
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_SET_BITS - 2)

`endif

// File: run_sim.sh
#!/bin/sh
# compile with verilator, run, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_cache \
	-f cache.f -o sim_cache \
	&& ./obj_dir/sim_cache | tee /dev/stderr | grep -q "All tests passed" \
	&& echo "simulation result: pass" \
	|| { echo "simulation result: fail"; exit 1; }

// File: source/cache_controller.sv
`default_nettype none

`include "cache_defs.svh"

module cache_controller
	import cache_pkg::*;
(
	input  wire                                      clk_i,
	input  wire                                      rst_n_i,
	// axi4-lite write address
	input  wire                                      awvalid_i,
	output logic                                     awready_o,
	input  wire  [`CACHE_ADDR_W-1:0]                 awaddr_i,
	// axi4-lite write data
	input  wire                                      wvalid_i,
	output logic                                     wready_o,
	input  wire  [`CACHE_DATA_W-1:0]                 wdata_i,
	input  wire  [`CACHE_DATA_W/8-1:0]               wstrb_i,
	// axi4-lite write response
	output logic                                     bvalid_o,
	input  wire                                      bready_i,
	output logic [1:0]                               bresp_o,
	// axi4-lite read address
	input  wire                                      arvalid_i,
	output logic                                     arready_o,
	input  wire  [`CACHE_ADDR_W-1:0]                 araddr_i,
	// axi4-lite read data
	output logic                                     rvalid_o,
	input  wire                                      rready_i,
	output logic [`CACHE_DATA_W-1:0]                 rdata_o,
	output logic [1:0]                               rresp_o,
	// store side
	output cache_addr_t                              addr_o,
	input  lookup_t                                  lookup_i,
	input  wire  [`CACHE_WAYS-1:0][`CACHE_DATA_W-1:0] way_data_i,
	output tag_op_e                                  tag_op_o,
	output way_t                                     tag_way_o,
	output logic                                     data_we_o,
	output way_t                                     data_way_o,
	output logic [`CACHE_DATA_W-1:0]                 data_wdata_o,
	// memory port
	output mem_req_t                                 mem_req_o,
	input  mem_rsp_t                                 mem_rsp_i
);

	ctrl_state_e              state_q;
	ctrl_state_e              state_d;
	// low in reset, then follows the idle state
	logic                     ready_q;
	// 1 for a write request, 0 for a read
	logic                     write_q;
	cache_addr_t              addr_q;
	logic [`CACHE_DATA_W-1:0] wdata_q;
	logic [`CACHE_DATA_W-1:0] rdata_q;
	logic                     ar_hs;
	logic                     aw_hs;

	// read wins over write
	// aw and w only taken as a pair
	assign arready_o = ready_q;
	assign awready_o = ready_q && awvalid_i && wvalid_i && !arvalid_i;
	assign wready_o  = awready_o;

	assign ar_hs = arvalid_i && arready_o;
	assign aw_hs = awvalid_i && awready_o;

	// responses held until taken
	assign rvalid_o = (state_q == READ_RESP);
	assign bvalid_o = (state_q == WRITE_RESP);
	assign rdata_o  = rdata_q;
	// always okay
	assign rresp_o  = 2'b00;
	assign bresp_o  = 2'b00;

	assign addr_o = addr_q;

	// next state
	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (ar_hs || aw_hs) begin
					state_d = LOOKUP;
				end
			end
			// single cycle for the stores to answer
			LOOKUP: begin
				if (write_q) begin
					state_d = MEM_WRITE;
				end else if (lookup_i.hit) begin
					state_d = READ_RESP;
				end else begin
					state_d = MEM_READ;
				end
			end
			MEM_READ: begin
				if (mem_rsp_i.ack) begin
					state_d = READ_RESP;
				end
			end
			MEM_WRITE: begin
				if (mem_rsp_i.ack) begin
					state_d = WRITE_RESP;
				end
			end
			READ_RESP: begin
				if (rready_i) begin
					state_d = IDLE;
				end
			end
			WRITE_RESP: begin
				if (bready_i) begin
					state_d = IDLE;
				end
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	// store updates
	// read hit touches at the end of lookup, miss fills on the ack edge
	always_comb begin
		tag_op_o     = NONE;
		tag_way_o    = lookup_i.hit_way;
		data_we_o    = 1'b0;
		data_way_o   = lookup_i.hit_way;
		data_wdata_o = wdata_q;
		if (state_q == LOOKUP && !write_q && lookup_i.hit) begin
			tag_op_o = TOUCH;
		end else if (state_q == MEM_READ && mem_rsp_i.ack) begin
			// victim way stays put while the set is unchanged
			tag_op_o     = FILL;
			tag_way_o    = lookup_i.victim_way;
			data_we_o    = 1'b1;
			data_way_o   = lookup_i.victim_way;
			data_wdata_o = mem_rsp_i.rdata;
		end else if (state_q == MEM_WRITE && mem_rsp_i.ack && lookup_i.hit) begin
			// write hit keeps the cached copy in step with memory
			tag_op_o  = TOUCH;
			data_we_o = 1'b1;
		end
	end

	// memory request straight from state and held registers
	always_comb begin
		mem_req_o.valid = (state_q == MEM_READ) || (state_q == MEM_WRITE);
		mem_req_o.we    = (state_q == MEM_WRITE);
		mem_req_o.addr  = {2'b00, addr_q.tag, addr_q.set_idx};
		mem_req_o.wdata = wdata_q;
	end

	// control state
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= IDLE;
			ready_q <= 1'b0;
			write_q <= 1'b0;
		end else begin
			state_q <= state_d;
			ready_q <= (state_d == IDLE);
			if (ar_hs) begin
				write_q <= 1'b0;
			end else if (aw_hs) begin
				write_q <= 1'b1;
			end
		end
	end

	// request payload and read result
	// partial strobes still write the whole word
	always_ff @(posedge clk_i) begin
		if (ar_hs) begin
			addr_q <= cache_addr_t'(araddr_i);
		end else if (aw_hs) begin
			addr_q  <= cache_addr_t'(awaddr_i);
			wdata_q <= wdata_i;
		end
		if (state_q == LOOKUP && !write_q && lookup_i.hit) begin
			rdata_q <= way_data_i[lookup_i.hit_way];
		end else if (state_q == MEM_READ && mem_rsp_i.ack) begin
			rdata_q <= mem_rsp_i.rdata;
		end
	end

endmodule

`default_nettype wire

// File: source/cache_data_store.sv
`default_nettype none

`include "cache_defs.svh"

module cache_data_store
	import cache_pkg::*;
(
	input  wire                                      clk_i,
	input  cache_addr_t                              addr_i,
	input  wire                                      we_i,
	input  way_t                                     we_way_i,
	input  wire  [`CACHE_DATA_W-1:0]                 wdata_i,
	output logic [`CACHE_WAYS-1:0][`CACHE_DATA_W-1:0] rdata_o
);

	localparam int SETS = 1 << `CACHE_SET_BITS;

	// one word per set and way
	logic [`CACHE_DATA_W-1:0] mem_q [SETS][`CACHE_WAYS];

	// all four ways of the set come out together
	// the controller picks one with the hit way
	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			rdata_o[w] = mem_q[addr_i.set_idx][w];
		end
	end

	// single way written per edge
	// fill data on a read miss, store data on a write hit
	always_ff @(posedge clk_i) begin
		if (we_i) begin
			mem_q[addr_i.set_idx][we_way_i] <= wdata_i;
		end
	end

endmodule

`default_nettype wire

// File: source/cache_pkg.sv
`default_nettype none

package cache_pkg;

	`include "cache_defs.svh"

	// byte address as seen by the cache
	typedef struct packed {
		logic [`CACHE_TAG_W-1:0]    tag;
		logic [`CACHE_SET_BITS-1:0] set_idx;
		// byte within the word, ignored for lookup
		logic [1:0]                 offset;
	} cache_addr_t;

	// way number inside a set
	typedef logic [1:0] way_t;

	// lru age, 3 is youngest and 0 is next to go
	typedef logic [1:0] age_t;

	// tag store answer for the addressed set
	typedef struct packed {
		logic hit;
		way_t hit_way;
		way_t victim_way;
	} lookup_t;

	// memory side request
	// held stable from valid until ack
	typedef struct packed {
		logic                     valid;
		logic                     we;
		// word address, byte address shifted down by two
		logic [`CACHE_ADDR_W-1:0] addr;
		logic [`CACHE_DATA_W-1:0] wdata;
	} mem_req_t;

	// memory side answer
	typedef struct packed {
		logic                     ack;
		logic [`CACHE_DATA_W-1:0] rdata;
	} mem_rsp_t;

	// controller states
	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		MEM_READ,
		MEM_WRITE,
		READ_RESP,
		WRITE_RESP
	} ctrl_state_e;

	// tag store update for one way
	typedef enum logic [1:0] {
		NONE,
		TOUCH,
		FILL
	} tag_op_e;

endpackage

`default_nettype wire

// File: source/cache_tag_store.sv
`default_nettype none

`include "cache_defs.svh"

module cache_tag_store
	import cache_pkg::*;
(
	input  wire         clk_i,
	input  wire         rst_n_i,
	input  cache_addr_t addr_i,
	input  tag_op_e     op_i,
	input  way_t        op_way_i,
	output lookup_t     lookup_o
);

	localparam int SETS = 1 << `CACHE_SET_BITS;

	// tag per set and way, payload only
	logic [`CACHE_TAG_W-1:0] tag_q [SETS][`CACHE_WAYS];
	// one valid bit per way, packed per set
	logic [`CACHE_WAYS-1:0]  valid_q [SETS];
	// ages of a set always form a permutation of 0..3
	age_t                    age_q [SETS][`CACHE_WAYS];

	// per-way tag match in the addressed set
	logic [`CACHE_WAYS-1:0]  match;
	// ages of the addressed set after the pending update
	age_t                    age_next [`CACHE_WAYS];

	// hit detection and victim choice
	always_comb begin
		lookup_o = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			match[w] = valid_q[addr_i.set_idx][w] &&
				(tag_q[addr_i.set_idx][w] == addr_i.tag);
		end
		lookup_o.hit = |match;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			// at most one way matches
			if (match[w]) begin
				lookup_o.hit_way = way_t'(w);
			end
		end
		// oldest way by default
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (age_q[addr_i.set_idx][w] == '0) begin
				lookup_o.victim_way = way_t'(w);
			end
		end
		// any invalid way wins, lowest number last so it takes priority
		for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
			if (!valid_q[addr_i.set_idx][w]) begin
				lookup_o.victim_way = way_t'(w);
			end
		end
	end

	// touched way becomes youngest, older ones step down
	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (way_t'(w) == op_way_i) begin
				age_next[w] = '1;
			end else if (age_q[addr_i.set_idx][w] > age_q[addr_i.set_idx][op_way_i]) begin
				age_next[w] = age_q[addr_i.set_idx][w] - 1'b1;
			end else begin
				age_next[w] = age_q[addr_i.set_idx][w];
			end
		end
	end

	// valid bits and ages
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int s = 0; s < SETS; s++) begin
				valid_q[s] <= '0;
				// age starts at the way number
				for (int w = 0; w < `CACHE_WAYS; w++) begin
					age_q[s][w] <= age_t'(w);
				end
			end
		end else if (op_i != NONE) begin
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				age_q[addr_i.set_idx][w] <= age_next[w];
			end
			if (op_i == FILL) begin
				valid_q[addr_i.set_idx][op_way_i] <= 1'b1;
			end
		end
	end

	// new tag only on a fill
	always_ff @(posedge clk_i) begin
		if (op_i == FILL) begin
			tag_q[addr_i.set_idx][op_way_i] <= addr_i.tag;
		end
	end

endmodule

`default_nettype wire

// File: source/cache_top.sv
`default_nettype none

`include "cache_defs.svh"

module cache_top
	import cache_pkg::*;
(
	input  wire                        clk_i,
	input  wire                        rst_n_i,
	// axi4-lite slave
	input  wire                        awvalid_i,
	output logic                       awready_o,
	input  wire  [`CACHE_ADDR_W-1:0]   awaddr_i,
	input  wire                        wvalid_i,
	output logic                       wready_o,
	input  wire  [`CACHE_DATA_W-1:0]   wdata_i,
	input  wire  [`CACHE_DATA_W/8-1:0] wstrb_i,
	output logic                       bvalid_o,
	input  wire                        bready_i,
	output logic [1:0]                 bresp_o,
	input  wire                        arvalid_i,
	output logic                       arready_o,
	input  wire  [`CACHE_ADDR_W-1:0]   araddr_i,
	output logic                       rvalid_o,
	input  wire                        rready_i,
	output logic [`CACHE_DATA_W-1:0]   rdata_o,
	output logic [1:0]                 rresp_o,
	// memory port
	output mem_req_t                   mem_req_o,
	input  mem_rsp_t                   mem_rsp_i
);

	// registered request address, shared by both stores
	cache_addr_t                              addr;
	lookup_t                                  lookup;
	// all ways of the addressed set
	logic [`CACHE_WAYS-1:0][`CACHE_DATA_W-1:0] way_data;
	tag_op_e                                  tag_op;
	way_t                                     tag_way;
	logic                                     data_we;
	way_t                                     data_way;
	logic [`CACHE_DATA_W-1:0]                 data_wdata;

	// tags, valid bits and ages
	cache_tag_store u_tag_store (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.addr_i   (addr),
		.op_i     (tag_op),
		.op_way_i (tag_way),
		.lookup_o (lookup)
	);

	// word storage, read side by side with the tags
	cache_data_store u_data_store (
		.clk_i    (clk_i),
		.addr_i   (addr),
		.we_i     (data_we),
		.we_way_i (data_way),
		.wdata_i  (data_wdata),
		.rdata_o  (way_data)
	);

	// axi slave fsm, merges both store results
	cache_controller u_controller (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.awvalid_i    (awvalid_i),
		.awready_o    (awready_o),
		.awaddr_i     (awaddr_i),
		.wvalid_i     (wvalid_i),
		.wready_o     (wready_o),
		.wdata_i      (wdata_i),
		.wstrb_i      (wstrb_i),
		.bvalid_o     (bvalid_o),
		.bready_i     (bready_i),
		.bresp_o      (bresp_o),
		.arvalid_i    (arvalid_i),
		.arready_o    (arready_o),
		.araddr_i     (araddr_i),
		.rvalid_o     (rvalid_o),
		.rready_i     (rready_i),
		.rdata_o      (rdata_o),
		.rresp_o      (rresp_o),
		.addr_o       (addr),
		.lookup_i     (lookup),
		.way_data_i   (way_data),
		.tag_op_o     (tag_op),
		.tag_way_o    (tag_way),
		.data_we_o    (data_we),
		.data_way_o   (data_way),
		.data_wdata_o (data_wdata),
		.mem_req_o    (mem_req_o),
		.mem_rsp_i    (mem_rsp_i)
	);

endmodule

`default_nettype wire

// File: testbench/cache_checker.sv
`default_nettype none

module cache_checker
	import cache_pkg::*;
(
	input wire        clk_i,
	input wire        rst_n_i,
	input wire        arvalid_i,
	input wire        arready_o,
	input wire [31:0] araddr_i,
	input wire        awvalid_i,
	input wire        awready_o,
	input wire [31:0] awaddr_i,
	input wire        wvalid_i,
	input wire        wready_o,
	input wire [31:0] wdata_i,
	input wire        rvalid_o,
	input wire        rready_i,
	input wire [31:0] rdata_o,
	input wire        bvalid_o,
	input wire        bready_i,
	input mem_req_t   mem_req_o,
	input mem_rsp_t   mem_rsp_i
);

	// request channels hold until accepted
	ar_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		arvalid_i && !arready_o |=> arvalid_i && $stable(araddr_i))
		else $error("ar channel changed before handshake");
	aw_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		awvalid_i && !awready_o |=> awvalid_i && $stable(awaddr_i))
		else $error("aw channel changed before handshake");
	w_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wvalid_i && !wready_o |=> wvalid_i && $stable(wdata_i))
		else $error("w channel changed before handshake");
	// responses held under back-pressure
	r_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o))
		else $error("r channel changed before handshake");
	b_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		bvalid_o && !bready_i |=> bvalid_o)
		else $error("bvalid dropped before handshake");
	// memory request frozen until ack
	mem_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		mem_req_o.valid && !mem_rsp_i.ack |=> mem_req_o.valid && $stable(mem_req_o))
		else $error("memory request changed before ack");
	// a pending response blocks a second response and any new request
	one_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		rvalid_o || bvalid_o |-> !(rvalid_o && bvalid_o) && !arready_o && !awready_o)
		else $error("second response or new request while a response is pending");

endmodule

bind cache_top cache_checker u_checker (
	.clk_i(clk_i), .rst_n_i(rst_n_i),
	.arvalid_i(arvalid_i), .arready_o(arready_o), .araddr_i(araddr_i),
	.awvalid_i(awvalid_i), .awready_o(awready_o), .awaddr_i(awaddr_i),
	.wvalid_i(wvalid_i), .wready_o(wready_o), .wdata_i(wdata_i),
	.rvalid_o(rvalid_o), .rready_i(rready_i), .rdata_o(rdata_o),
	.bvalid_o(bvalid_o), .bready_i(bready_i),
	.mem_req_o(mem_req_o), .mem_rsp_i(mem_rsp_i)
);

`default_nettype wire

// File: testbench/tb_cache.sv
`default_nettype none

`include "cache_defs.svh"

module tb_cache
	import cache_pkg::*;
;

	localparam int TOTAL_TX = 480;
	// handshake, lookup, slow memory and longest stall
	localparam int TX_CYCLES = 40;
	localparam int CYCLE_LIMIT = TOTAL_TX * TX_CYCLES;

	logic clk_i, rst_n_i;
	logic awvalid_i, wvalid_i, arvalid_i, bready_i, rready_i;
	logic awready_o, wready_o, arready_o, bvalid_o, rvalid_o;
	logic [31:0] awaddr_i, wdata_i, araddr_i, rdata_o;
	logic [3:0] wstrb_i;
	logic [1:0] bresp_o, rresp_o;
	mem_req_t mem_req_o;
	mem_rsp_t mem_rsp_i;

	logic [15:0] stim_lfsr;
	logic [15:0] mem_lfsr;
	int errors, checks, cycle_cnt;
	// memory model state
	logic [31:0] mem [logic [31:0]];
	logic mem_busy;
	logic [1:0] mem_wait;
	int mem_reads, mem_writes;
	logic [31:0] last_waddr, last_wdata;
	// cache model state
	logic [25:0] m_tag [16][4];
	logic m_valid [16][4];
	int m_age [16][4];

	cache_top UUT (.*);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one lfsr step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			stim_lfsr = lfsr_next(stim_lfsr);
			v = {v[30:0], stim_lfsr[0]};
		end
		return v;
	endfunction

	// untouched memory word depends on every address bit
	function automatic logic [31:0] mem_word(input logic [31:0] wa);
		if (mem.exists(wa)) begin
			return mem[wa];
		end
		return (wa * 32'h9E3779B1) ^ {wa[15:0], wa[31:16]} ^ 32'h5A5A_0F0F;
	endfunction

	function automatic logic [31:0] make_addr(input logic [25:0] tag, input logic [3:0] set);
		return {tag, set, 2'(take_bits(2))};
	endfunction

	// memory answers after 1 to 4 cycles
	always @(posedge clk_i) begin
		if (mem_rsp_i.ack) begin
			mem_rsp_i.ack <= 1'b0;
			mem_busy <= 1'b0;
		end else if (mem_req_o.valid) begin
			if (!mem_busy) begin
				mem_busy <= 1'b1;
				mem_lfsr = lfsr_next(lfsr_next(mem_lfsr));
				mem_wait <= mem_lfsr[1:0];
			end else if (mem_wait == 0) begin
				mem_rsp_i.ack <= 1'b1;
				if (mem_req_o.we) begin
					mem[mem_req_o.addr] = mem_req_o.wdata;
					mem_writes <= mem_writes + 1;
					last_waddr <= mem_req_o.addr;
					last_wdata <= mem_req_o.wdata;
				end else begin
					mem_rsp_i.rdata <= mem_word(mem_req_o.addr);
					mem_reads <= mem_reads + 1;
				end
			end else begin
				mem_wait <= mem_wait - 1'b1;
			end
		end
	end

	always @(posedge clk_i) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, a handshake never completed", cycle_cnt);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic touch(input int s, input int w);
		int old;
		old = m_age[s][w];
		for (int i = 0; i < 4; i++) begin
			if (m_age[s][i] > old) begin
				m_age[s][i]--;
			end
		end
		m_age[s][w] = 3;
	endtask

	// predicts hit and updates tags and ages
	task automatic model_access(input logic [31:0] a, input bit is_write, output bit hit);
		int s;
		int v;
		s = a[5:2];
		hit = 1'b0;
		v = -1;
		for (int w = 0; w < 4; w++) begin
			if (m_valid[s][w] && m_tag[s][w] == a[31:6]) begin
				hit = 1'b1;
				v = w;
			end
		end
		if (hit) begin
			touch(s, v);
		end else if (!is_write) begin
			for (int w = 3; w >= 0; w--) begin
				if (!m_valid[s][w]) v = w;
			end
			if (v < 0) begin
				for (int w = 0; w < 4; w++) begin
					if (m_age[s][w] == 0) v = w;
				end
			end
			m_valid[s][v] = 1'b1;
			m_tag[s][v] = a[31:6];
			touch(s, v);
		end
	endtask

	// response stall with stability checks
	task automatic hold_response(input bit bp, input bit is_read, input logic [31:0] held);
		int stall;
		stall = bp ? int'(take_bits(3)) : 0;
		repeat (stall) begin
			@(posedge clk_i);
			@(negedge clk_i);
			checks++;
			if (is_read && (!rvalid_o || rdata_o != held)) begin
				$display("FAILED rdata: got %h expected %h (rvalid %h)", rdata_o, held, rvalid_o);
				errors++;
			end
			if (!is_read && !bvalid_o) begin
				$display("write response dropped while bready was low");
				errors++;
			end
			if (mem_req_o.valid) begin
				$display("memory request started before the response was taken");
				errors++;
			end
		end
		@(posedge clk_i);
		if (is_read) rready_i <= 1'b1;
		else bready_i <= 1'b1;
		@(posedge clk_i);
		rready_i <= 1'b0;
		bready_i <= 1'b0;
	endtask

	task automatic do_read(input logic [31:0] a, input bit bp, output bit missed);
		logic [31:0] exp_data;
		bit exp_hit;
		int rd0;
		int lat;
		exp_data = mem_word(a >> 2);
		model_access(a, 1'b0, exp_hit);
		rd0 = mem_reads;
		@(posedge clk_i);
		arvalid_i <= 1'b1;
		araddr_i <= a;
		do @(negedge clk_i); while (!arready_o);
		@(posedge clk_i);
		arvalid_i <= 1'b0;
		lat = 1;
		forever begin
			@(negedge clk_i);
			if (rvalid_o) break;
			lat++;
			@(posedge clk_i);
		end
		missed = (mem_reads != rd0);
		checks++;
		if (rdata_o != exp_data) begin
			$display("FAILED rdata: got %h expected %h at %h", rdata_o, exp_data, a);
			errors++;
		end
		if (rresp_o != 2'b00) begin
			$display("FAILED rresp: got %h expected %h", rresp_o, 2'b00);
			errors++;
		end
		if (mem_reads - rd0 != (exp_hit ? 0 : 1)) begin
			$display("read of %h made %0d memory reads, model expects a %s", a,
				mem_reads - rd0, exp_hit ? "hit" : "miss");
			errors++;
		end
		if (exp_hit && lat != 2) begin
			$display("read hit at %h took %0d edges instead of 2", a, lat);
			errors++;
		end
		hold_response(bp, 1'b1, exp_data);
	endtask

	task automatic do_write(input logic [31:0] a, input logic [31:0] d, input bit bp);
		bit exp_hit;
		int wr0;
		model_access(a, 1'b1, exp_hit);
		wr0 = mem_writes;
		@(posedge clk_i);
		awvalid_i <= 1'b1;
		wvalid_i <= 1'b1;
		awaddr_i <= a;
		wdata_i <= d;
		wstrb_i <= 4'(take_bits(4));
		do @(negedge clk_i); while (!awready_o && !wready_o);
		// aw and w are taken together
		checks++;
		if (awready_o != 1'b1) begin
			$display("FAILED awready_o: got %h expected %h", awready_o, 1'b1);
			errors++;
		end
		if (wready_o != 1'b1) begin
			$display("FAILED wready_o: got %h expected %h", wready_o, 1'b1);
			errors++;
		end
		@(posedge clk_i);
		awvalid_i <= 1'b0;
		wvalid_i <= 1'b0;
		do @(negedge clk_i); while (!bvalid_o);
		checks++;
		if (mem_writes - wr0 != 1) begin
			$display("write to %h made %0d memory writes instead of one", a, mem_writes - wr0);
			errors++;
		end
		if (last_waddr != (a >> 2)) begin
			$display("FAILED mem_req_o.addr: got %h expected %h", last_waddr, a >> 2);
			errors++;
		end
		if (last_wdata != d) begin
			$display("FAILED mem_req_o.wdata: got %h expected %h", last_wdata, d);
			errors++;
		end
		if (bresp_o != 2'b00) begin
			$display("FAILED bresp: got %h expected %h", bresp_o, 2'b00);
			errors++;
		end
		hold_response(bp, 1'b0, '0);
	endtask

	task automatic report_test(input string name, input int err0);
		$display("test %s: %s, %0d errors", name, (errors == err0) ? "ok" : "FAILED",
			errors - err0);
	endtask

	initial begin
		int err0;
		bit missed;
		logic [31:0] a;
		awvalid_i = 1'b0;
		wvalid_i = 1'b0;
		arvalid_i = 1'b0;
		bready_i = 1'b0;
		rready_i = 1'b0;
		awaddr_i = '0;
		wdata_i = '0;
		araddr_i = '0;
		wstrb_i = '0;
		mem_rsp_i = '0;
		mem_busy = 1'b0;
		mem_wait = '0;
		mem_reads = 0;
		mem_writes = 0;
		last_waddr = '0;
		last_wdata = '0;
		stim_lfsr = 16'd66;
		mem_lfsr = 16'd66;
		errors = 0;
		checks = 0;
		cycle_cnt = 0;
		for (int s = 0; s < 16; s++) begin
			for (int w = 0; w < 4; w++) begin
				m_valid[s][w] = 1'b0;
				m_tag[s][w] = '0;
				m_age[s][w] = w;
			end
		end
		rst_n_i = 1'b0;
		repeat (8) @(posedge clk_i);
		rst_n_i <= 1'b1;

		// first read fills and the repeat hits
		err0 = errors;
		do_read(make_addr(26'h11, 4'd1), 1'b0, missed);
		do_read(make_addr(26'h11, 4'd1), 1'b0, missed);
		do_read(make_addr(26'h12, 4'd1), 1'b0, missed);
		do_read(make_addr(26'h12, 4'd1), 1'b0, missed);
		report_test("read_miss_hit", err0);

		// write-through to cached and uncached lines
		err0 = errors;
		do_write(make_addr(26'h11, 4'd1), 32'hCAFE_0001, 1'b0);
		do_read(make_addr(26'h11, 4'd1), 1'b0, missed);
		do_write(make_addr(26'h21, 4'd3), 32'hBEEF_0002, 1'b0);
		do_read(make_addr(26'h21, 4'd3), 1'b0, missed);
		report_test("write_through", err0);

		// five tags in set 5, then the first must miss
		err0 = errors;
		for (int t = 0; t < 5; t++) begin
			do_read(make_addr(26'h100 + t, 4'd5), 1'b0, missed);
		end
		do_read(make_addr(26'h100, 4'd5), 1'b0, missed);
		checks++;
		if (!missed) begin
			$display("first tag of set 5 still hit after four newer fills");
			errors++;
		end
		// touching tag 0 before the fill sends tag 1 out
		for (int t = 0; t < 4; t++) begin
			do_read(make_addr(26'h200 + t, 4'd6), 1'b0, missed);
		end
		do_read(make_addr(26'h200, 4'd6), 1'b0, missed);
		do_read(make_addr(26'h204, 4'd6), 1'b0, missed);
		do_read(make_addr(26'h200, 4'd6), 1'b0, missed);
		do_read(make_addr(26'h201, 4'd6), 1'b0, missed);
		report_test("lru_eviction", err0);

		err0 = errors;
		for (int i = 0; i < 20; i++) begin
			a = make_addr(26'h40 + 26'(take_bits(3)), 4'd2 + 4'(take_bits(1)));
			if (take_bits(1)) do_write(a, take_bits(32), 1'b1);
			else do_read(a, 1'b1, missed);
		end
		report_test("back_pressure", err0);

		err0 = errors;
		for (int i = 0; i < 400; i++) begin
			a = make_addr(26'h40 + 26'(take_bits(3)), 4'd2 + 4'(take_bits(1)));
			if (take_bits(1)) do_write(a, take_bits(32), take_bits(2) == 0);
			else do_read(a, take_bits(2) == 0, missed);
		end
		report_test("random_traffic", err0);

		$display("checks %0d, errors %0d, memory reads %0d, memory writes %0d",
			checks, errors, mem_reads, mem_writes);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
